//--- bench/axiLiteTasks.svh
//######################################################################
// AXI4-Lite master tasks for the coprocessor testbench.
// Included inside the bench module. Each task starts and ends right
// after a rising clock edge; hold gives the cycles BREADY or RREADY
// stay low once the response is valid. writeReg leaves in acceptWait
// the number of edges it waited for AWREADY and WREADY.
//######################################################################

task automatic writeReg(input logic [4:0] addr, input logic [31:0] data, input int hold);
	int cycles;
	int i;
	awAddr  <= addr;
	awValid <= 1'b1;
	wData   <= data;
	wValid  <= 1'b1;
	cycles = 0;
	do begin
		@(posedge CLK);
		cycles++;
		if (cycles > waitLimit) begin
			abortOnTimeout("write address and data were never accepted");
		end
	end while (!(awReady && wReady));
	acceptWait = cycles;
	awValid <= 1'b0;
	wValid  <= 1'b0;
	cycles = 0;
	while (!bValid) begin
		@(posedge CLK);
		cycles++;
		if (cycles > waitLimit) begin
			abortOnTimeout("write response never arrived");
		end
	end
	for (i = 0; i < hold; i++) begin
		@(posedge CLK);
		if (!bValid) begin
			busError("write response dropped while BREADY was low");
		end
	end
	bReady <= 1'b1;
	@(posedge CLK); // bValid is already high, so this edge is the handshake
	if (!bValid || bResp !== 2'b00) begin
		busError("write response missing or not OKAY at the handshake");
	end
	bReady <= 1'b0;
endtask

task automatic readReg(input logic [4:0] addr, input int hold, output logic [31:0] data);
	int cycles;
	int i;
	logic [31:0] firstData;
	arAddr  <= addr;
	arValid <= 1'b1;
	cycles = 0;
	do begin
		@(posedge CLK);
		cycles++;
		if (cycles > waitLimit) begin
			abortOnTimeout("read address was never accepted");
		end
	end while (!arReady);
	arValid <= 1'b0;
	cycles = 0;
	while (!rValid) begin
		@(posedge CLK);
		cycles++;
		if (cycles > waitLimit) begin
			abortOnTimeout("read data never arrived");
		end
	end
	firstData = rData;
	for (i = 0; i < hold; i++) begin
		@(posedge CLK);
		if (!rValid || rData !== firstData) begin
			busError("read data dropped or changed while RREADY was low");
		end
	end
	rReady <= 1'b1;
	@(posedge CLK);
	if (!rValid || rResp !== 2'b00) begin
		busError("read response missing or not OKAY at the handshake");
	end
	data = rData;
	rReady <= 1'b0;
endtask

//--- bench/aluCoprocTb.sv
//######################################################################
// Testbench for the AXI4-Lite ALU coprocessor.
// Drives commands over the bus, predicts result, flags, error and
// op count with its own model and compares what STATUS and RESULT
// read back. Prints one line per test and a closing count.
//######################################################################
`timescale 1ns/1ps

module aluCoprocTb;
	import aluPkg::*;

	localparam int BITS      = 16;
	localparam int waitLimit = 200; // cycles per wait and polls per command
	localparam int fFlag     = BITS;
	localparam int fCnt      = BITS + 3;
	localparam int fErr      = BITS + 11;
	localparam int fOp       = BITS + 12;

	typedef logic [BITS+15:0] obsT; // {op, error, count, flags SZC, result}

	logic        CLK = 1'b0;
	logic        RSTb;
	logic [4:0]  awAddr;
	logic        awValid;
	logic        awReady;
	logic [31:0] wData;
	logic        wValid;
	logic        wReady;
	logic        bValid;
	logic [1:0]  bResp;
	logic        bReady;
	logic [4:0]  arAddr;
	logic        arValid;
	logic        arReady;
	logic        rValid;
	logic [31:0] rData;
	logic [1:0]  rResp;
	logic        rReady;

	logic [BITS-1:0] mResult; // model of the coprocessor state
	logic [2:0]      mFlags;
	logic [7:0]      mCount;
	logic            mErr;
	aluOpE           mCmd;
	logic [31:0]     rngState;
	int              errorCount;
	int              checksDone;
	int              errAtOpen;
	int              acceptWait;
	string           testName;
	obsT             expQ[$];
	obsT             actQ[$];
	string           nameQ[$];

	aluCoprocTop #(.BITS(BITS)) dut_i (
		.CLK(CLK), .RSTb(RSTb),
		.awAddr(awAddr), .awValid(awValid), .awReady(awReady),
		.wData(wData), .wValid(wValid), .wReady(wReady),
		.bValid(bValid), .bResp(bResp), .bReady(bReady),
		.arAddr(arAddr), .arValid(arValid), .arReady(arReady),
		.rValid(rValid), .rData(rData), .rResp(rResp), .rReady(rReady)
	);

	always #5 CLK = ~CLK;

	task automatic reportAndFinish();
		$display("checks run: %0d, errors: %0d", checksDone, errorCount);
		if (errorCount == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	endtask

	task automatic abortOnTimeout(input string what);
		$display("timeout in test %s: %s", testName, what);
		errorCount++;
		reportAndFinish();
	endtask

	task automatic busError(input string what);
		$display("bus protocol error in test %s: %s", testName, what);
		errorCount++;
	endtask

	`include "axiLiteTasks.svh"

	function automatic logic [31:0] lcgNext();
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return rngState;
	endfunction

	function automatic logic [BITS-1:0] randomOperand();
		logic [31:0] r;
		r = lcgNext();
		return BITS'(r >> (32 - BITS)); // upper bits have the longer period
	endfunction

	// expected {S, Z, C, result} for one legal op
	function automatic logic [BITS+2:0] refAlu(input aluOpE op, input logic [BITS-1:0] a,
			input logic [BITS-1:0] b, input logic [2:0] fl);
		logic [BITS-1:0] r;
		logic c;
		logic z;
		logic s;
		r = '0;
		c = fl[0];
		z = fl[1];
		s = fl[2];
		case (op)
			opMov: r = a;
			opClc: c = 1'b0;
			opSec: c = 1'b1;
			opClz: z = 1'b0;
			opSez: z = 1'b1;
			opCls: s = 1'b0;
			opSes: s = 1'b1;
			opAdd: begin
				r = a + b;
				c = (r < a); // the sum wrapped past all ones
				z = (r == '0);
				s = r[BITS-1];
			end
			opSub: begin
				r = a - b;
				c = (b > a); // borrow
				z = (r == '0);
				s = r[BITS-1];
			end
			opAnd, opOr, opXor: begin
				r = (op == opAnd) ? (a & b) : (op == opOr) ? (a | b) : (a ^ b);
				z = (r == '0);
			end
			opRol: begin
				r = (a << 1) | BITS'(fl[0]);
				c = a[BITS-1];
			end
			opRor: begin
				r = (a >> 1) | (BITS'(fl[0]) << (BITS - 1));
				c = a[0];
			end
			default: r = '0;
		endcase
		return {s, z, c, r};
	endfunction

	function automatic obsT packObs(input logic [BITS-1:0] res, input logic [2:0] fl,
			input logic [7:0] cnt, input logic err, input aluOpE op);
		return {op, err, cnt, fl, res};
	endfunction

	task automatic checkResult(input string name, input logic [BITS-1:0] exp,
			input logic [BITS-1:0] act);
		checksDone++;
		if (act !== exp) begin
			errorCount++;
			$display("[FAIL] %s result: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic checkFlags(input string name, input logic [2:0] exp, input logic [2:0] act);
		checksDone++;
		if (act !== exp) begin
			errorCount++;
			$display("[FAIL] %s flags SZC: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic checkOp(input string name, input aluOpE exp, input aluOpE act);
		checksDone++;
		if (act !== exp) begin
			errorCount++;
			$display("[FAIL] %s command: expected %s, actual %s", name, exp.name(), act.name());
		end
	endtask

	task automatic checkCount(input string name, input logic [7:0] exp, input logic [7:0] act);
		checksDone++;
		if (act !== exp) begin
			errorCount++;
			$display("[FAIL] %s opCount: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic checkError(input string name, input logic exp, input logic act);
		checksDone++;
		if (act !== exp) begin
			errorCount++;
			$display("[FAIL] %s error bit: expected %b, actual %b", name, exp, act);
		end
	endtask

	// pairs up predicted and observed readbacks as they arrive
	always @(posedge CLK) begin : compareObs
		obsT   e;
		obsT   a;
		string n;
		while (expQ.size() > 0 && actQ.size() > 0) begin
			e = expQ.pop_front();
			a = actQ.pop_front();
			n = nameQ.pop_front();
			checkResult(n, e[BITS-1:0], a[BITS-1:0]);
			checkFlags(n, e[fFlag+2:fFlag], a[fFlag+2:fFlag]);
			checkCount(n, e[fCnt+7:fCnt], a[fCnt+7:fCnt]);
			checkError(n, e[fErr], a[fErr]);
			checkOp(n, aluOpE'(e[fOp+3:fOp]), aluOpE'(a[fOp+3:fOp]));
		end
	end

	task automatic applyModel(input aluOpE op, input logic [BITS-1:0] a, input logic [BITS-1:0] b);
		mCmd = op;
		if (op == opMul || op == opMuls) begin
			mErr = 1'b1; // result, flags and count stay as they are
		end else begin
			{mFlags, mResult} = refAlu(op, a, b, mFlags);
			mCount++;
		end
	endtask

	// polls until idle, then reads RESULT and CMD and queues both views
	task automatic collectStatus(input string name, input int hold);
		logic [31:0] status;
		logic [31:0] resWord;
		logic [31:0] cmdWord;
		int polls;
		polls = 0;
		do begin
			readReg(regStatus, hold, status);
			polls++;
			if (polls > waitLimit) begin
				abortOnTimeout("busy never went low");
			end
		end while (status[stBusy]);
		readReg(regResult, hold, resWord);
		readReg(regCmd, hold, cmdWord);
		expQ.push_back(packObs(mResult, mFlags, mCount, mErr, mCmd));
		actQ.push_back(packObs(resWord[BITS-1:0], status[2:0], status[stCountHi:stCountLo],
			status[stError], aluOpE'(cmdWord[3:0])));
		nameQ.push_back(name);
	endtask

	task automatic issueCommand(input string name, input aluOpE op, input logic [BITS-1:0] a,
			input logic [BITS-1:0] b, input int hold);
		writeReg(regA, 32'(a), hold);
		writeReg(regB, 32'(b), hold);
		writeReg(regCmd, 32'(op), hold);
		applyModel(op, a, b);
		collectStatus(name, hold);
	endtask

	task automatic openTest(input string name);
		testName  = name;
		errAtOpen = errorCount;
	endtask

	task automatic closeTest();
		int cycles;
		cycles = 0;
		while (expQ.size() > 0) begin
			@(posedge CLK);
			cycles++;
			if (cycles > waitLimit) begin
				abortOnTimeout("queued comparisons never drained");
			end
		end
		if (errorCount == errAtOpen) begin
			$display("test %s: passed", testName);
		end else begin
			$display("test %s: %0d errors", testName, errorCount - errAtOpen);
		end
	endtask

	task automatic flagSequence();
		aluOpE seq[6];
		int i;
		seq = '{opSec, opSez, opSes, opClc, opClz, opCls};
		openTest("flagSequence");
		for (i = 0; i < 6; i++) begin
			issueCommand($sformatf("flag %s", seq[i].name()), seq[i], randomOperand(),
				randomOperand(), 0);
		end
		closeTest();
	endtask

	task automatic addSubSweep();
		logic [BITS-1:0] a;
		logic [BITS-1:0] b;
		int i;
		openTest("addSubSweep");
		for (i = 0; i < 200; i++) begin
			a = randomOperand();
			b = randomOperand();
			if (i == 0) begin
				b = a; // equal operands give a zero difference
			end else if (i == 1) begin
				a = '1;
				b = '1;
			end else if (i == 2) begin
				a = '1;
				b = 1;
			end
			issueCommand($sformatf("add #%0d", i), opAdd, a, b, 0);
			issueCommand($sformatf("sub #%0d", i), opSub, a, b, 0);
		end
		closeTest();
	endtask

	task automatic logicOps();
		aluOpE ops[4];
		logic [BITS-1:0] a;
		logic [BITS-1:0] b;
		aluOpE op;
		int i;
		ops = '{opAnd, opOr, opXor, opMov};
		openTest("logicOps");
		issueCommand("logic setC", opSec, '0, '0, 0); // C and S must survive
		issueCommand("logic setS", opSes, '0, '0, 0);
		for (i = 0; i < 40; i++) begin
			a = randomOperand();
			b = (i == 0) ? ~a : randomOperand();
			op = ops[lcgNext() >> 30];
			if (i == 1) begin
				op = opXor;
				b = a;
			end
			issueCommand($sformatf("logic #%0d %s", i, op.name()), op, a, b, 0);
		end
		closeTest();
	endtask

	task automatic rotateChains();
		logic [BITS-1:0] val;
		aluOpE op;
		int pass;
		int i;
		openTest("rotateChains");
		for (pass = 0; pass < 2; pass++) begin
			op = (pass == 0) ? opSec : opClc;
			issueCommand($sformatf("rotate seed %s", op.name()), op, '0, '0, 0);
			val = randomOperand();
			for (i = 0; i < 10; i++) begin
				op = (lcgNext() >> 31) ? opRol : opRor;
				issueCommand($sformatf("rotate %0d.%0d %s", pass, i, op.name()), op, val, '0, 0);
				val = mResult; // each step rotates the last result
			end
		end
		closeTest();
	endtask

	task automatic illegalOps();
		openTest("illegalOps");
		issueCommand("illegal before", opAdd, randomOperand(), randomOperand(), 0);
		issueCommand("illegal mul", opMul, randomOperand(), randomOperand(), 0);
		issueCommand("illegal muls", opMuls, randomOperand(), randomOperand(), 0);
		writeReg(regStatus, 32'd0, 0);
		mErr = 1'b0;
		collectStatus("illegal cleared", 0);
		issueCommand("illegal muls again", opMuls, randomOperand(), randomOperand(), 0);
		issueCommand("illegal then legal", opXor, randomOperand(), randomOperand(), 0);
		writeReg(regStatus, 32'd0, 0);
		mErr = 1'b0;
		collectStatus("illegal cleared again", 0); // count has wrapped past 256 by now
		closeTest();
	endtask

	task automatic backPressure();
		logic [BITS-1:0] a;
		logic [BITS-1:0] b;
		aluOpE op;
		int hold;
		int i;
		openTest("backPressure");
		for (i = 0; i < 30; i++) begin
			hold = lcgNext() >> 29;
			op = (lcgNext() >> 31) ? opAdd : opSub;
			issueCommand($sformatf("stretch #%0d hold %0d", i, hold), op, randomOperand(),
				randomOperand(), hold);
		end
		a = randomOperand();
		b = randomOperand();
		hold = lcgNext() >> 29;
		writeReg(regA, 32'(a), 0);
		writeReg(regB, 32'(b), 0);
		writeReg(regCmd, 32'(opSub), 0);
		applyModel(opSub, a, b);
		writeReg(regCmd, 32'(opRol), hold); // stalls until the sub retires
		checksDone++;
		if (acceptWait < 2) begin
			errorCount++;
			$display("back to back: second command was accepted while the first was in flight");
		end
		applyModel(opRol, a, b);
		collectStatus("back to back", hold);
		closeTest();
	endtask

	initial begin
		RSTb       = 1'b0;
		awAddr     = '0;
		awValid    = 1'b0;
		wData      = '0;
		wValid     = 1'b0;
		bReady     = 1'b0;
		arAddr     = '0;
		arValid    = 1'b0;
		rReady     = 1'b0;
		rngState   = 32'heeee_0b6e;
		mResult    = '0;
		mFlags     = 3'b000;
		mCount     = 8'd0;
		mErr       = 1'b0;
		mCmd       = opMov;
		errorCount = 0;
		checksDone = 0;
		acceptWait = 0;
		testName   = "reset";
		repeat (4) @(posedge CLK);
		RSTb <= 1'b1;
		@(posedge CLK);
		flagSequence();
		addSubSweep();
		logicOps();
		rotateChains();
		illegalOps();
		backPressure();
		reportAndFinish();
	end

endmodule

//--- build.f
+incdir+bench
hdl/aluPkg.sv
hdl/axiLiteSlave.sv
hdl/opDecode.sv
hdl/flagAlu.sv
hdl/resultStage.sv
hdl/aluCoprocTop.sv
bench/aluCoprocTb.sv

//--- hdl/aluCoprocTop.sv
//######################################################################
// Top level of the AXI4-Lite ALU coprocessor.
// Connects the bus slave to the decode, execute and result stages and
// passes the operand width BITS down to every stage that needs it.
//######################################################################
`timescale 1ns/1ps

module aluCoprocTop #(
	parameter int BITS = 16 // operand width, 2 to 32
) (
	input  logic        CLK,
	input  logic        RSTb,
	input  logic [4:0]  awAddr,
	input  logic        awValid,
	output logic        awReady,
	input  logic [31:0] wData,
	input  logic        wValid,
	output logic        wReady,
	output logic        bValid,
	output logic [1:0]  bResp,
	input  logic        bReady,
	input  logic [4:0]  arAddr,
	input  logic        arValid,
	output logic        arReady,
	output logic        rValid,
	output logic [31:0] rData,
	output logic [1:0]  rResp,
	input  logic        rReady
);
	import aluPkg::*;

	logic [BITS-1:0] opA;
	logic [BITS-1:0] opB;
	logic            start;
	logic [3:0]      cmdOp;
	logic            errClear;
	logic            decValid;
	aluOpE           decOp;
	logic            decIllegal;
	logic            exValid;
	logic            exIllegal;
	logic [BITS-1:0] aluOut;
	logic            flagC;
	logic            flagZ;
	logic            flagS;
	logic [BITS-1:0] result;
	logic            busy;
	logic            error;
	logic [7:0]      opCount;

	axiLiteSlave #(.BITS(BITS)) slave_i (
		.CLK(CLK), .RSTb(RSTb),
		.awAddr(awAddr), .awValid(awValid), .awReady(awReady),
		.wData(wData), .wValid(wValid), .wReady(wReady),
		.bValid(bValid), .bResp(bResp), .bReady(bReady),
		.arAddr(arAddr), .arValid(arValid), .arReady(arReady),
		.rValid(rValid), .rData(rData), .rResp(rResp), .rReady(rReady),
		.busy(busy), .error(error), .opCount(opCount), .result(result),
		.flagC(flagC), .flagZ(flagZ), .flagS(flagS),
		.opA(opA), .opB(opB), .start(start), .cmdOp(cmdOp), .errClear(errClear)
	);

	opDecode decode_i (
		.CLK(CLK), .RSTb(RSTb), .start(start), .cmdOp(cmdOp),
		.decValid(decValid), .decOp(decOp), .decIllegal(decIllegal)
	);

	flagAlu #(.BITS(BITS)) alu_i (
		.CLK(CLK), .RSTb(RSTb),
		.decValid(decValid), .decOp(decOp), .decIllegal(decIllegal),
		.opA(opA), .opB(opB),
		.exValid(exValid), .exIllegal(exIllegal), .aluOut(aluOut),
		.flagC(flagC), .flagZ(flagZ), .flagS(flagS)
	);

	resultStage #(.BITS(BITS)) result_i (
		.CLK(CLK), .RSTb(RSTb), .start(start),
		.exValid(exValid), .exIllegal(exIllegal), .aluOut(aluOut),
		.errClear(errClear),
		.result(result), .busy(busy), .error(error), .opCount(opCount)
	);

endmodule

//--- hdl/aluPkg.sv
//######################################################################
// Shared types and constants for the ALU coprocessor.
// Holds the opcode encoding, the AXI slave channel states, the
// register byte offsets and the STATUS bit positions.
//######################################################################
package aluPkg;

	typedef enum logic [3:0] {
		opMov  = 4'd0,
		opClc  = 4'd1,
		opSec  = 4'd2,
		opClz  = 4'd3,
		opSez  = 4'd4,
		opCls  = 4'd5,
		opSes  = 4'd6,
		opAdd  = 4'd7,
		opSub  = 4'd8,
		opMul  = 4'd9,  // decoded illegal since multiply is not built
		opMuls = 4'd10, // decoded illegal since multiply is not built
		opAnd  = 4'd11,
		opOr   = 4'd12,
		opXor  = 4'd13,
		opRol  = 4'd14,
		opRor  = 4'd15
	} aluOpE;

	typedef enum logic [1:0] {
		wrIdle  = 2'd0,
		wrResp  = 2'd1,
		wrStall = 2'd2 // command write held off while busy
	} wrStateE;

	typedef enum logic {
		rdIdle = 1'b0,
		rdResp = 1'b1
	} rdStateE;

	localparam logic [4:0] regA      = 5'h00;
	localparam logic [4:0] regB      = 5'h04;
	localparam logic [4:0] regCmd    = 5'h08;
	localparam logic [4:0] regResult = 5'h0C;
	localparam logic [4:0] regStatus = 5'h10;

	localparam int stC       = 0;
	localparam int stZ       = 1;
	localparam int stS       = 2;
	localparam int stBusy    = 3;
	localparam int stError   = 4;
	localparam int stCountLo = 8;
	localparam int stCountHi = 15;

endpackage

//--- hdl/axiLiteSlave.sv
//######################################################################
// AXI4-Lite slave of the ALU coprocessor.
// Holds operands A and B, turns writes to CMD into one-cycle start
// pulses and stalls them while a command is in flight. Reads return
// the operands, the last command, the result and the status word.
//######################################################################
`timescale 1ns/1ps

module axiLiteSlave #(
	parameter int BITS = 16
) (
	input  logic            CLK,
	input  logic            RSTb,
	input  logic [4:0]      awAddr,
	input  logic            awValid,
	output logic            awReady,
	input  logic [31:0]     wData,
	input  logic            wValid,
	output logic            wReady,
	output logic            bValid,
	output logic [1:0]      bResp,
	input  logic            bReady,
	input  logic [4:0]      arAddr,
	input  logic            arValid,
	output logic            arReady,
	output logic            rValid,
	output logic [31:0]     rData,
	output logic [1:0]      rResp,
	input  logic            rReady,
	input  logic            busy,
	input  logic            error,
	input  logic [7:0]      opCount,
	input  logic [BITS-1:0] result,
	input  logic            flagC,
	input  logic            flagZ,
	input  logic            flagS,
	output logic [BITS-1:0] opA,
	output logic [BITS-1:0] opB,
	output logic            start,
	output logic [3:0]      cmdOp,
	output logic            errClear
);
	import aluPkg::*;

	localparam logic [1:0] respOkay = 2'b00;

	wrStateE     wrState;
	rdStateE     rdState;
	logic        wrBoth;
	logic        cmdBlocked;
	logic        wrFire;
	logic        arFire;
	logic [31:0] statusWord;
	logic [31:0] readWord;

	assign wrBoth     = awValid && wValid;
	assign cmdBlocked = (awAddr == regCmd) && busy; // only one command in flight
	assign awReady    = (wrState == wrIdle) && wrBoth && !cmdBlocked;
	assign wReady     = awReady; // address and data are taken together
	assign wrFire     = awValid && awReady && wValid && wReady;
	assign bValid     = (wrState == wrResp);
	assign bResp      = respOkay;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			wrState <= wrIdle;
		end else begin
			case (wrState)
				wrIdle: begin
					if (wrFire) begin
						wrState <= wrResp;
					end else if (wrBoth && cmdBlocked) begin
						wrState <= wrStall;
					end
				end
				wrResp: begin
					if (bReady) begin
						wrState <= wrIdle;
					end
				end
				wrStall: begin
					if (!busy) begin
						wrState <= wrIdle; // retry the held command from idle
					end
				end
				default: wrState <= wrIdle;
			endcase
		end
	end

	// start and errClear line up with the cycle bValid rises
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			start    <= 1'b0;
			errClear <= 1'b0;
		end else begin
			start    <= wrFire && (awAddr == regCmd);
			errClear <= wrFire && (awAddr == regStatus);
		end
	end

	always_ff @(posedge CLK) begin
		if (wrFire && (awAddr == regA)) begin
			opA <= wData[BITS-1:0];
		end
		if (wrFire && (awAddr == regB)) begin
			opB <= wData[BITS-1:0];
		end
		if (wrFire && (awAddr == regCmd)) begin
			cmdOp <= wData[3:0];
		end
	end

	assign arReady = (rdState == rdIdle) && arValid;
	assign arFire  = arValid && arReady;
	assign rValid  = (rdState == rdResp);
	assign rResp   = respOkay;

	always_comb begin
		statusWord                       = '0;
		statusWord[stC]                  = flagC;
		statusWord[stZ]                  = flagZ;
		statusWord[stS]                  = flagS;
		statusWord[stBusy]               = busy;
		statusWord[stError]              = error;
		statusWord[stCountHi:stCountLo]  = opCount;
	end

	always_comb begin
		readWord = '0; // unmapped offsets read as zero
		case (arAddr)
			regA:      readWord[BITS-1:0] = opA;
			regB:      readWord[BITS-1:0] = opB;
			regCmd:    readWord[3:0]      = cmdOp;
			regResult: readWord[BITS-1:0] = result;
			regStatus: readWord           = statusWord;
			default:   readWord           = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			rdState <= rdIdle;
		end else if (arFire) begin
			rdState <= rdResp;
		end else if (rValid && rReady) begin
			rdState <= rdIdle;
		end
	end

	always_ff @(posedge CLK) begin
		if (arFire) begin
			rData <= readWord; // held stable while rValid waits
		end
	end

	property bValidHold;
		@(posedge CLK) disable iff (!RSTb)
		bValid && !bReady |=> bValid;
	endproperty

	assert property (bValidHold)
		else $error("write response dropped before the master accepted it");

endmodule

//--- hdl/flagAlu.sv
//######################################################################
// Execute stage: the ALU that keeps carry, zero and sign flags.
// One operation per decValid; result and flags are registered and
// exValid follows one cycle later. Illegal ops leave all state alone.
//######################################################################
`timescale 1ns/1ps

module flagAlu #(
	parameter int BITS = 16
) (
	input  logic            CLK,
	input  logic            RSTb,
	input  logic            decValid,
	input  aluPkg::aluOpE   decOp,
	input  logic            decIllegal,
	input  logic [BITS-1:0] opA,
	input  logic [BITS-1:0] opB,
	output logic            exValid,
	output logic            exIllegal,
	output logic [BITS-1:0] aluOut,
	output logic            flagC,
	output logic            flagZ,
	output logic            flagS
);
	import aluPkg::*;

	logic [BITS:0]   addSum;
	logic [BITS:0]   subDiff;
	logic [BITS-1:0] andVal;
	logic [BITS-1:0] orVal;
	logic [BITS-1:0] xorVal;
	logic [BITS-1:0] rolVal;
	logic [BITS-1:0] rorVal;
	logic [BITS-1:0] nextOut;
	logic            nextC;
	logic            nextZ;
	logic            nextS;
	logic            update;

	assign addSum  = {1'b0, opA} + {1'b0, opB};
	assign subDiff = {1'b0, opA} - {1'b0, opB}; // top bit is the borrow
	assign andVal  = opA & opB;
	assign orVal   = opA | opB;
	assign xorVal  = opA ^ opB;
	assign rolVal  = {opA[BITS-2:0], flagC}; // rotates go through carry
	assign rorVal  = {flagC, opA[BITS-1:1]};

	always_comb begin
		nextC   = flagC; // flags hold unless the op says otherwise
		nextZ   = flagZ;
		nextS   = flagS;
		nextOut = '0;
		case (decOp)
			opMov: nextOut = opA;
			opClc: nextC = 1'b0;
			opSec: nextC = 1'b1;
			opClz: nextZ = 1'b0;
			opSez: nextZ = 1'b1;
			opCls: nextS = 1'b0;
			opSes: nextS = 1'b1;
			opAdd: begin
				nextOut = addSum[BITS-1:0];
				nextC   = addSum[BITS];
				nextZ   = ~|addSum[BITS-1:0];
				nextS   = addSum[BITS-1];
			end
			opSub: begin
				nextOut = subDiff[BITS-1:0];
				nextC   = subDiff[BITS];
				nextZ   = ~|subDiff[BITS-1:0];
				nextS   = subDiff[BITS-1];
			end
			opMul, opMuls: nextOut = '0; // flagged illegal in decode
			opAnd: begin
				nextOut = andVal;
				nextZ   = ~|andVal;
			end
			opOr: begin
				nextOut = orVal;
				nextZ   = ~|orVal;
			end
			opXor: begin
				nextOut = xorVal;
				nextZ   = ~|xorVal;
			end
			opRol: begin
				nextOut = rolVal;
				nextC   = opA[BITS-1];
			end
			opRor: begin
				nextOut = rorVal;
				nextC   = opA[0];
			end
			default: nextOut = '0;
		endcase
	end

	assign update = decValid && !decIllegal;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			exValid   <= 1'b0;
			exIllegal <= 1'b0;
			flagC     <= 1'b0;
			flagZ     <= 1'b0;
			flagS     <= 1'b0;
		end else begin
			exValid   <= decValid;
			exIllegal <= decValid && decIllegal;
			if (update) begin
				flagC <= nextC;
				flagZ <= nextZ;
				flagS <= nextS;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (update) begin
			aluOut <= nextOut;
		end
	end

	property flagsOnlyAfterOp;
		@(posedge CLK) disable iff (!RSTb)
		!decValid |=> $stable({flagC, flagZ, flagS});
	endproperty

	assert property (flagsOnlyAfterOp)
		else $error("ALU flags changed without a decoded operation");

endmodule

//--- hdl/opDecode.sv
//######################################################################
// Decode stage of the coprocessor pipeline.
// Registers the command opcode as an enum one cycle after start and
// marks the multiply opcodes, which are not implemented, as illegal.
//######################################################################
`timescale 1ns/1ps

module opDecode (
	input  logic          CLK,
	input  logic          RSTb,
	input  logic          start,
	input  logic [3:0]    cmdOp,
	output logic          decValid,
	output aluPkg::aluOpE decOp,
	output logic          decIllegal
);
	import aluPkg::*;

	aluOpE opCode;
	logic  illegalOp;

	assign opCode = aluOpE'(cmdOp); // every 4-bit code has a name

	always_comb begin
		case (opCode)
			opMul, opMuls: illegalOp = 1'b1;
			default:       illegalOp = 1'b0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			decValid <= 1'b0;
		end else begin
			decValid <= start;
		end
	end

	// op and illegal mark only mean something while decValid is high
	always_ff @(posedge CLK) begin
		if (start) begin
			decOp      <= opCode;
			decIllegal <= illegalOp;
		end
	end

	property decOpKnown;
		@(posedge CLK) disable iff (!RSTb)
		decValid |-> !$isunknown({decOp, decIllegal});
	endproperty

	assert property (decOpKnown)
		else $error("decoded opcode is unknown while decValid is high");

endmodule

//--- hdl/resultStage.sv
//######################################################################
// Result stage of the coprocessor pipeline.
// Stores the ALU output of each legal op, tracks busy from start to
// retire, keeps the sticky error bit and counts completed operations.
//######################################################################
`timescale 1ns/1ps

module resultStage #(
	parameter int BITS = 16
) (
	input  logic            CLK,
	input  logic            RSTb,
	input  logic            start,
	input  logic            exValid,
	input  logic            exIllegal,
	input  logic [BITS-1:0] aluOut,
	input  logic            errClear,
	output logic [BITS-1:0] result,
	output logic            busy,
	output logic            error,
	output logic [7:0]      opCount
);

	logic retireOk;

	assign retireOk = exValid && !exIllegal;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			result  <= '0;
			busy    <= 1'b0;
			error   <= 1'b0;
			opCount <= 8'd0;
		end else begin
			if (start) begin
				busy <= 1'b1;
			end else if (exValid) begin
				busy <= 1'b0; // low the cycle after the op retires
			end
			if (retireOk) begin
				result  <= aluOut;
				opCount <= opCount + 8'd1; // wraps at 256
			end
			if (exValid && exIllegal) begin
				error <= 1'b1; // a new error beats a clear in the same cycle
			end else if (errClear) begin
				error <= 1'b0;
			end
		end
	end

	property noStartWhileBusy;
		@(posedge CLK) disable iff (!RSTb)
		start |-> !busy;
	endproperty

	assert property (noStartWhileBusy)
		else $error("new command started while the previous one is in flight");

endmodule
